// ==== Bender.yml ====
package:
  name: path_oram_stress

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/oramPkg.sv
      - source/dramPkg.sv
      - source/PathFifo.sv
      - source/BurstKeystream.sv
      - source/PathAddrGen.sv
      - source/PathReencrypter.sv
      - source/PathOramStress.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/dramModel.sv
      - testbench/tbPathOramStress.sv

// ==== sim.f ====
+incdir+source
source/oramPkg.sv
source/dramPkg.sv
source/PathFifo.sv
source/BurstKeystream.sv
source/PathAddrGen.sv
source/PathReencrypter.sv
source/PathOramStress.sv
testbench/dramModel.sv
testbench/tbPathOramStress.sv

// ==== source/BurstKeystream.sv ====
// Stand-in cipher keystream with fixed latency of two cycles
// Accepts one request per cycle and has no back-pressure
`default_nettype none
`include "pathOram_defs.svh"

module BurstKeystream
	import oramPkg::*;
	import dramPkg::*;
(
	input  wire logic     Clock,
	input  wire logic     arstN,
	input  wire ivT       Iv,
	input  wire burstPosT Chunk,
	input  wire logic     InValid,
	output burstT         Key,
	output logic          KeyValid
);

	localparam int ChunkW = `DDR_DWIDTH - `IV_WIDTH;

	burstT product;
	logic  productValid;

	// Stage one multiplies the seed word, IV above the chunk index
	// Stage two folds high bits down with the xorshift
	always_ff @(posedge Clock) begin
		product <= {Iv, ChunkW'(Chunk)} * burstT'(`KEY_MUL);
		Key     <= product ^ (product >> 29);
	end

	// Valid bits travel with the data
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			productValid <= 1'b0;
			KeyValid     <= 1'b0;
		end else begin
			productValid <= InValid;
			KeyValid     <= productValid;
		end
	end

endmodule

`default_nettype wire

// ==== source/PathAddrGen.sv ====
// Issues one read path then the same write path per random leaf
// Waits for PathDone between paths and stops drawing leaves on Error
`default_nettype none
`include "pathOram_defs.svh"

module PathAddrGen
	import oramPkg::*;
	import dramPkg::*;
(
	input  wire logic Clock,
	input  wire logic arstN,
	input  wire logic PathDone,
	input  wire logic Error,
	output dramCmdT   Cmd,
	output logic      CmdValid,
	input  wire logic CmdReady
);

	localparam int LvlW  = $clog2(`ORAM_L + 1);
	localparam int AddrW = `DDR_AWIDTH;

	typedef enum logic [1:0] {StIdle, StRead, StWrite, StWaitDone} stateT;

	stateT           state;
	logic [31:0]     lfsr;
	logic [31:0]     lfsrNext;
	leafT            leaf;
	logic [LvlW-1:0] level;
	burstPosT        burstPos;
	bucketIdxT       levelBase;
	bucketIdxT       bucketIdx;
	logic [AddrW-1:0] burstAddr;
	logic            cmdFire;
	logic            lastBurst;
	logic            doneSeen;

	// ------------------------------------------------------------
	// Leaf source
	// ------------------------------------------------------------
	// Galois step, right shifting
	assign lfsrNext = lfsr[0] ? ((lfsr >> 1) ^ `LFSR_TAPS) : (lfsr >> 1);

	// ------------------------------------------------------------
	// Address rule
	// ------------------------------------------------------------
	// First heap index of this level
	assign levelBase = (bucketIdxT'(1) << level) - bucketIdxT'(1);
	// Leaf prefix picks the bucket within the level
	assign bucketIdx = levelBase + bucketIdxT'(leaf >> (LvlW'(`ORAM_L) - level));
	assign burstAddr = AddrW'(bucketIdx) * AddrW'(`BKT_BURSTS) + AddrW'(burstPos);

	always_comb begin
		Cmd.op   = (state == StWrite) ? OpWrite : OpRead;
		Cmd.addr = burstAddr;
	end

	assign CmdValid  = (state == StRead) || (state == StWrite);
	assign cmdFire   = CmdValid && CmdReady;
	assign lastBurst = (level == LvlW'(`ORAM_L)) &&
		(burstPos == burstPosT'(`BKT_BURSTS - 1));

	// ------------------------------------------------------------
	// Phase FSM and burst counters
	// ------------------------------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state    <= StIdle;
			lfsr     <= `LFSR_SEED;
			leaf     <= '0;
			level    <= '0;
			burstPos <= '0;
			doneSeen <= 1'b0;
		end else begin
			// Consumer may finish before the last write command leaves
			if (PathDone) begin
				doneSeen <= 1'b1;
			end
			// Counters wrap to the root after the last burst
			if (cmdFire) begin
				burstPos <= burstPos + burstPosT'(1);
				if (burstPos == burstPosT'(`BKT_BURSTS - 1)) begin
					level <= lastBurst ? '0 : level + LvlW'(1);
				end
			end
			case (state)
				StIdle: begin
					if (!Error) begin
						lfsr  <= lfsrNext;
						leaf  <= leafT'(lfsrNext);
						state <= StRead;
					end
				end
				StRead: begin
					if (cmdFire && lastBurst) begin
						state <= StWrite;
					end
				end
				StWrite: begin
					if (cmdFire && lastBurst) begin
						state <= StWaitDone;
					end
				end
				default: begin
					if (PathDone || doneSeen) begin
						state    <= StIdle;
						doneSeen <= 1'b0;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/PathFifo.sv ====
// First-word fall-through FIFO with valid/ready on both sides
// Depth need not be a power of two
`default_nettype none

module PathFifo #(
	parameter type payloadT = logic,
	parameter int  Depth    = 4
) (
	input  wire logic    Clock,
	input  wire logic    arstN,
	input  wire payloadT InData,
	input  wire logic    InValid,
	output logic         InReady,
	output payloadT      OutData,
	output logic         OutValid,
	input  wire logic    OutReady
);

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntW = $clog2(Depth + 1);

	payloadT         mem [Depth];
	logic [PtrW-1:0] rdPtr;
	logic [PtrW-1:0] wrPtr;
	logic [CntW-1:0] fill;
	logic            push;
	logic            pop;

	// Circular increment
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + PtrW'(1);
	endfunction

	assign InReady  = fill != CntW'(Depth);
	assign OutValid = fill != '0;
	// Head entry shows without a pop
	assign OutData  = mem[rdPtr];
	assign push     = InValid && InReady;
	assign pop      = OutValid && OutReady;

	always_ff @(posedge Clock) begin
		if (push) begin
			mem[wrPtr] <= InData;
		end
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			fill  <= '0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// Simultaneous push and pop leaves the fill unchanged
			if (push && !pop) begin
				fill <= fill + CntW'(1);
			end else if (pop && !push) begin
				fill <= fill - CntW'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/PathOramStress.sv ====
// Path ORAM traffic stress tester top
// Memory must be preloaded with buckets encrypted under IV zero
`default_nettype none
`include "pathOram_defs.svh"

module PathOramStress
	import dramPkg::*;
(
	input  wire logic   Clock,
	input  wire logic   arstN,
	output dramCmdT     Cmd,
	output logic        CmdValid,
	input  wire logic   CmdReady,
	input  wire burstT  RdData,
	input  wire logic   RdValid,
	output burstT       WrData,
	output logic        WrValid,
	input  wire logic   WrReady,
	output logic        Error,
	output logic        DataMismatch,
	output logic [15:0] PathCount
);

	burstT rdFifoData;
	logic  rdFifoValid;
	logic  rdFifoReady;
	burstT wrFifoData;
	logic  wrFifoValid;
	logic  wrFifoReady;
	logic  pathDone;

	// ------------------------------------------------------------
	// Command producer
	// ------------------------------------------------------------
	PathAddrGen i_addrGen (
		.Clock    (Clock),
		.arstN    (arstN),
		.PathDone (pathDone),
		.Error    (Error),
		.Cmd      (Cmd),
		.CmdValid (CmdValid),
		.CmdReady (CmdReady)
	);

	// Holds a whole path so read data needs no ready
	PathFifo #(
		.payloadT (burstT),
		.Depth    (`RD_FIFO_DEPTH)
	) i_rdFifo (
		.Clock    (Clock),
		.arstN    (arstN),
		.InData   (RdData),
		.InValid  (RdValid),
		.InReady  (),
		.OutData  (rdFifoData),
		.OutValid (rdFifoValid),
		.OutReady (rdFifoReady)
	);

	// ------------------------------------------------------------
	// Data path
	// ------------------------------------------------------------
	PathReencrypter i_reencrypter (
		.Clock        (Clock),
		.arstN        (arstN),
		.RdBurst      (rdFifoData),
		.RdValid      (rdFifoValid),
		.RdReady      (rdFifoReady),
		.WrBurst      (wrFifoData),
		.WrValid      (wrFifoValid),
		.WrReady      (wrFifoReady),
		.PathDone     (pathDone),
		.Error        (Error),
		.DataMismatch (DataMismatch),
		.PathCount    (PathCount)
	);

	PathFifo #(
		.payloadT (burstT),
		.Depth    (`WR_FIFO_DEPTH)
	) i_wrFifo (
		.Clock    (Clock),
		.arstN    (arstN),
		.InData   (wrFifoData),
		.InValid  (wrFifoValid),
		.InReady  (wrFifoReady),
		.OutData  (WrData),
		.OutValid (WrValid),
		.OutReady (WrReady)
	);

endmodule

`default_nettype wire

// ==== source/PathReencrypter.sv ====
// Checks every read data burst decrypts to zero then rewrites the path
// Assumes one path in flight and reads arriving root first in burst order
`default_nettype none
`include "pathOram_defs.svh"

module PathReencrypter
	import oramPkg::*;
	import dramPkg::*;
(
	input  wire logic   Clock,
	input  wire logic   arstN,
	input  wire burstT  RdBurst,
	input  wire logic   RdValid,
	output logic        RdReady,
	output burstT       WrBurst,
	output logic        WrValid,
	input  wire logic   WrReady,
	output logic        PathDone,
	output logic        Error,
	output logic        DataMismatch,
	output logic [15:0] PathCount
);

	localparam int LvlW      = $clog2(`ORAM_L + 1);
	localparam int KeyQDepth = 4;
	localparam int KeyQW     = $clog2(KeyQDepth);
	localparam int KeyCntW   = $clog2(KeyQDepth + 1);

	typedef enum logic [1:0] {PhRead, PhDrain, PhWrite} phaseT;

	// Read burst that rides alongside its keystream
	typedef struct packed {
		burstT data;
		logic  last;
	} rdTagT;

	phaseT            phase;
	// Read side
	logic [LvlW-1:0]  rdLevel;
	burstPosT         rdPos;
	ivT               curIv;
	logic             rdFire;
	logic             rdLast;
	logic             checkValid;
	rdTagT            tagStage1;
	rdTagT            tagStage2;
	// Keystream port
	ivT               ksIv;
	burstPosT         ksChunk;
	logic             ksValid;
	burstT            key;
	logic             keyValid;
	// Write side
	ivT               wrIvBase;
	logic [LvlW-1:0]  reqLevel;
	logic [LvlW-1:0]  outLevel;
	burstPosT         reqChunk;
	burstPosT         outPos;
	logic             reqDone;
	logic             keyReq;
	burstT            keyQ [KeyQDepth];
	logic [KeyQW-1:0] keyHead;
	logic [KeyQW-1:0] keyTail;
	logic [KeyCntW-1:0] keyCnt;
	logic [KeyCntW-1:0] keyOut;
	logic             outHeader;
	logic             outLast;
	logic             wrFire;
	logic             keyPush;
	logic             keyPop;

	// ------------------------------------------------------------
	// Read side
	// ------------------------------------------------------------
	assign RdReady    = phase == PhRead;
	assign rdFire     = RdValid && RdReady;
	assign rdLast     = (rdLevel == LvlW'(`ORAM_L)) && (rdPos == burstPosT'(`BKT_BURSTS - 1));
	assign checkValid = keyValid && (phase != PhWrite);

	always_ff @(posedge Clock) begin
		if (rdFire && rdPos == '0) begin
			curIv <= RdBurst[`IV_WIDTH-1:0];
		end
		// Two stages to line up with the keystream latency
		tagStage1 <= '{data: RdBurst, last: rdLast};
		tagStage2 <= tagStage1;
	end

	// ------------------------------------------------------------
	// Shared keystream
	// ------------------------------------------------------------
	// Write requests run ahead of the output, bounded by queue space
	assign keyReq  = (phase == PhWrite) && !reqDone && (keyOut != KeyCntW'(KeyQDepth));
	assign ksValid = (rdFire && rdPos != '0) || keyReq;
	assign ksIv    = (phase == PhWrite) ? wrIvBase + ivT'(reqLevel) : curIv;
	assign ksChunk = (phase == PhWrite) ? reqChunk : rdPos;

	BurstKeystream i_keystream (
		.Clock    (Clock),
		.arstN    (arstN),
		.Iv       (ksIv),
		.Chunk    (ksChunk),
		.InValid  (ksValid),
		.Key      (key),
		.KeyValid (keyValid)
	);

	// ------------------------------------------------------------
	// Write side
	// ------------------------------------------------------------
	assign outHeader = outPos == '0;
	assign outLast   = (outLevel == LvlW'(`ORAM_L)) && (outPos == burstPosT'(`BKT_BURSTS - 1));
	assign WrValid   = (phase == PhWrite) && (outHeader || keyCnt != '0);
	// Header carries its fresh IV with zeros above
	assign WrBurst   = outHeader ? burstT'(wrIvBase + ivT'(outLevel)) : keyQ[keyHead];
	assign wrFire    = WrValid && WrReady;
	assign keyPush   = keyValid && (phase == PhWrite);
	assign keyPop    = wrFire && !outHeader;

	always_ff @(posedge Clock) begin
		if (keyPush) begin
			keyQ[keyTail] <= key;
		end
	end

	// ------------------------------------------------------------
	// Control
	// ------------------------------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			phase        <= PhRead;
			rdLevel      <= '0;
			rdPos        <= '0;
			wrIvBase     <= ivT'(1);
			reqLevel     <= '0;
			reqChunk     <= burstPosT'(1);
			reqDone      <= 1'b0;
			outLevel     <= '0;
			outPos       <= '0;
			keyHead      <= '0;
			keyTail      <= '0;
			keyCnt       <= '0;
			keyOut       <= '0;
			PathDone     <= 1'b0;
			PathCount    <= '0;
			DataMismatch <= 1'b0;
			Error        <= 1'b0;
		end else begin
			PathDone <= 1'b0;
			Error    <= Error | DataMismatch;
			// Any nonzero plaintext bit is sticky
			if (checkValid && (tagStage2.data ^ key) != '0) begin
				DataMismatch <= 1'b1;
			end
			if (rdFire) begin
				rdPos <= rdPos + burstPosT'(1);
				if (rdPos == burstPosT'(`BKT_BURSTS - 1)) begin
					rdLevel <= rdLast ? '0 : rdLevel + LvlW'(1);
				end
			end
			case (phase)
				PhRead: begin
					if (rdFire && rdLast) begin
						phase <= PhDrain;
					end
				end
				// Last data burst of the path is checked here
				PhDrain: begin
					if (checkValid && tagStage2.last) begin
						phase <= PhWrite;
					end
				end
				default: begin
					if (wrFire && outLast) begin
						phase <= PhRead;
					end
				end
			endcase
			// Request pointer skips header slots
			if (keyReq) begin
				if (reqChunk == burstPosT'(`BKT_BURSTS - 1)) begin
					reqChunk <= burstPosT'(1);
					if (reqLevel == LvlW'(`ORAM_L)) begin
						reqDone <= 1'b1;
					end else begin
						reqLevel <= reqLevel + LvlW'(1);
					end
				end else begin
					reqChunk <= reqChunk + burstPosT'(1);
				end
			end
			if (wrFire) begin
				outPos <= outPos + burstPosT'(1);
				if (outPos == burstPosT'(`BKT_BURSTS - 1)) begin
					outLevel <= outLast ? '0 : outLevel + LvlW'(1);
				end
				// Path end, IVs move on by one per bucket
				if (outLast) begin
					reqDone   <= 1'b0;
					reqLevel  <= '0;
					wrIvBase  <= wrIvBase + ivT'(`ORAM_L + 1);
					PathDone  <= 1'b1;
					PathCount <= PathCount + 16'd1;
				end
			end
			if (keyPush) begin
				keyTail <= keyTail + KeyQW'(1);
			end
			if (keyPop) begin
				keyHead <= keyHead + KeyQW'(1);
			end
			keyCnt <= keyCnt + KeyCntW'(keyPush) - KeyCntW'(keyPop);
			keyOut <= keyOut + KeyCntW'(keyReq) - KeyCntW'(keyPop);
		end
	end

endmodule

`default_nettype wire

// ==== source/dramPkg.sv ====
// DRAM side types
// Command addresses count bursts and not bytes
`default_nettype none
`include "pathOram_defs.svh"

package dramPkg;

	// One DRAM data burst
	typedef logic [`DDR_DWIDTH-1:0] burstT;

	// Command opcodes
	typedef enum logic {
		OpRead  = 1'b0,
		OpWrite = 1'b1
	} dramOpT;

	// Command beat
	// Held stable by the sender until accepted
	typedef struct packed {
		dramOpT                 op;
		logic [`DDR_AWIDTH-1:0] addr;
	} dramCmdT;

endpackage

`default_nettype wire

// ==== source/oramPkg.sv ====
// Tree side types
// Widths follow ORAM_L and IV_WIDTH from the sizing header
`default_nettype none
`include "pathOram_defs.svh"

package oramPkg;

	// ------------------------------------------------------------
	// Tree addressing
	// ------------------------------------------------------------

	// Leaf label with one bit per level below the root
	typedef logic [`ORAM_L-1:0] leafT;

	// Heap index of a bucket
	// Root is index zero
	typedef logic [`ORAM_L:0] bucketIdxT;

	// Burst slot inside a bucket
	// Slot zero is the header
	typedef logic [1:0] burstPosT;

	// ------------------------------------------------------------
	// Bucket header
	// ------------------------------------------------------------

	// IV sits in the low bits of the header burst
	typedef logic [`IV_WIDTH-1:0] ivT;

endpackage

`default_nettype wire

// ==== source/pathOram_defs.svh ====
// Sizing for the Path ORAM DRAM stress tester
// Bucket layout is fixed at one header burst plus three data bursts
`ifndef PATH_ORAM_DEFS_SVH
`define PATH_ORAM_DEFS_SVH

// ------------------------------------------------------------
// Tree shape
// ------------------------------------------------------------
// Levels below the root so a path holds ORAM_L+1 buckets
`define ORAM_L        4
`define BKT_BURSTS    4
`define PATH_BURSTS   20

// ------------------------------------------------------------
// DRAM and crypto widths
// ------------------------------------------------------------
`define DDR_DWIDTH    64
`define DDR_AWIDTH    24
`define IV_WIDTH      32

// Read FIFO must hold one full path
`define RD_FIFO_DEPTH 32
`define WR_FIFO_DEPTH 8

// Odd multiplier for the keystream mix
`define KEY_MUL       64'h9E37_79B9_7F4A_7C15
// Leaf generator state
`define LFSR_SEED     32'h1D87_2B41
`define LFSR_TAPS     32'h8020_0003

`endif

// ==== testbench/dramModel.sv ====
// In-order DRAM model addressed in bursts, with optional random ready stalls
// Reads wait for earlier writes to land, and read latency varies on every command
`default_nettype none
`include "pathOram_defs.svh"

module dramModel
	import dramPkg::*;
#(
	parameter int Words = 128
) (
	input  wire logic    Clock,
	input  wire logic    arstN,
	input  wire logic    StallEn,
	input  wire logic    FlipArm,
	input  wire dramCmdT Cmd,
	input  wire logic    CmdValid,
	output logic         CmdReady,
	output burstT        RdData,
	output logic         RdValid,
	input  wire burstT   WrData,
	input  wire logic    WrValid,
	output logic         WrReady
);

	timeunit 1ns;
	timeprecision 100ps;

	// Read in flight with the cycle it may return
	typedef struct packed {
		burstT data;
		int    due;
	} rdItemT;

	burstT                  mem [Words];
	rdItemT                 rdQ [$];
	rdItemT                 item;
	logic [`DDR_AWIDTH-1:0] wrQ [$];
	int                     cycle;
	int                     lastDue;
	logic                   flipped;

	// Backdoor load used before the run starts
	task automatic loadBurst(input int addr, input burstT data);
		mem[addr] = data;
	endtask

	// ------------------------------------------------------------
	// Everything is driven and decided on the falling edge
	// ------------------------------------------------------------
	initial begin
		CmdReady = 1'b0;
		WrReady  = 1'b0;
		RdValid  = 1'b0;
		RdData   = '0;
		cycle    = 0;
		lastDue  = 0;
		flipped  = 1'b0;
		forever begin
			@(negedge Clock);
			cycle++;
			if (!arstN) begin
				// Drop whatever was in flight
				rdQ.delete();
				wrQ.delete();
				flipped  = 1'b0;
				CmdReady = 1'b0;
				WrReady  = 1'b0;
				RdValid  = 1'b0;
				RdData   = '0;
			end else begin
				// Oldest read returns once its latency is up
				RdValid = 1'b0;
				RdData  = '0;
				if (rdQ.size() > 0 && rdQ[0].due <= cycle) begin
					item    = rdQ.pop_front();
					RdValid = 1'b1;
					RdData  = item.data;
				end
				CmdReady = StallEn ? ($urandom % 2 == 0) : 1'b1;
				// A read may not pass a write that still waits for data
				if (CmdValid && Cmd.op == OpRead && wrQ.size() > 0) begin
					CmdReady = 1'b0;
				end
				// Transfer happens on the coming rising edge
				if (CmdValid && CmdReady) begin
					if (Cmd.op == OpRead) begin
						item.data = mem[int'(Cmd.addr)];
						// One bit error on the first data burst after arming
						if (FlipArm && !flipped && (Cmd.addr % `BKT_BURSTS) != 0) begin
							item.data[5] = ~item.data[5];
							flipped      = 1'b1;
						end
						item.due = cycle + 2 + int'($urandom % 4);
						// Keep returns in order, one per cycle
						if (item.due <= lastDue) begin
							item.due = lastDue + 1;
						end
						lastDue = item.due;
						rdQ.push_back(item);
					end else begin
						wrQ.push_back(Cmd.addr);
					end
				end
				// Write data pairs with write commands in order
				WrReady = (StallEn ? ($urandom % 2 == 0) : 1'b1) && (wrQ.size() > 0);
				if (WrValid && WrReady) begin
					mem[int'(wrQ.pop_front())] = WrData;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tbPathOramStress.sv ====
// Runs reset, unstalled, stalled and error-injection tests on the stress tester
// Memory is preloaded with every bucket encrypted under IV zero
`default_nettype none
`include "pathOram_defs.svh"

module tbPathOramStress
	import oramPkg::*;
	import dramPkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ClockPeriodNs = 4;
	localparam int PathsPerTest  = 8;
	localparam int CyclesPerPath = 200;
	localparam int NumTests      = 4;
	localparam int WatchdogNs    = PathsPerTest * CyclesPerPath * NumTests * ClockPeriodNs + 2000;
	localparam int NumBuckets    = (1 << (`ORAM_L + 1)) - 1;
	localparam int MemWords      = 128;
	localparam int CmdsPerPath   = 2 * `PATH_BURSTS;

	logic        Clock = 1'b0;
	logic        arstN;
	logic        StallEn;
	logic        FlipArm;
	dramCmdT     Cmd;
	logic        CmdValid;
	logic        CmdReady;
	burstT       RdData;
	logic        RdValid;
	burstT       WrData;
	logic        WrValid;
	logic        WrReady;
	logic        Error;
	logic        DataMismatch;
	logic [15:0] PathCount;

	string       curTest;
	int          errors;
	int          testErrorsAtStart;
	int          testsRun;
	int          testsFailed;
	int          cmdIdx;
	int          wrIdx;

	always #(ClockPeriodNs / 2) Clock = ~Clock;

	PathOramStress i_dut (
		.Clock        (Clock),
		.arstN        (arstN),
		.Cmd          (Cmd),
		.CmdValid     (CmdValid),
		.CmdReady     (CmdReady),
		.RdData       (RdData),
		.RdValid      (RdValid),
		.WrData       (WrData),
		.WrValid      (WrValid),
		.WrReady      (WrReady),
		.Error        (Error),
		.DataMismatch (DataMismatch),
		.PathCount    (PathCount)
	);

	dramModel #(
		.Words (MemWords)
	) i_dram (
		.Clock    (Clock),
		.arstN    (arstN),
		.StallEn  (StallEn),
		.FlipArm  (FlipArm),
		.Cmd      (Cmd),
		.CmdValid (CmdValid),
		.CmdReady (CmdReady),
		.RdData   (RdData),
		.RdValid  (RdValid),
		.WrData   (WrData),
		.WrValid  (WrValid),
		.WrReady  (WrReady)
	);

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	// Leaf of a path, one Galois step per path from the seed
	function automatic leafT refLeaf(input int pathIdx);
		logic [31:0] lfsr;
		int          i;
		lfsr = `LFSR_SEED;
		for (i = 0; i <= pathIdx; i++) begin
			if (lfsr[0]) begin
				lfsr = (lfsr >> 1) ^ `LFSR_TAPS;
			end else begin
				lfsr = lfsr >> 1;
			end
		end
		return leafT'(lfsr);
	endfunction

	// Heap index of the bucket at this level, then burst slot
	function automatic logic [`DDR_AWIDTH-1:0] refAddr(input leafT leaf, input int level,
		input int pos);
		int bucket;
		bucket = (1 << level) - 1 + (int'(leaf) >> (`ORAM_L - level));
		return `DDR_AWIDTH'(bucket * `BKT_BURSTS + pos);
	endfunction

	// IV above chunk, multiply, then xorshift by 29
	function automatic burstT refKeystream(input ivT iv, input int chunk);
		burstT seed;
		burstT product;
		seed    = (burstT'(iv) << (`DDR_DWIDTH - `IV_WIDTH)) | burstT'(chunk);
		product = seed * burstT'(`KEY_MUL);
		return product ^ (product >> 29);
	endfunction

	// Write IVs start at 1 and count one per bucket across paths
	function automatic burstT refWriteBurst(input int pathIdx, input int b);
		ivT iv;
		iv = ivT'(1 + pathIdx * (`ORAM_L + 1) + b / `BKT_BURSTS);
		if (b % `BKT_BURSTS == 0) begin
			return burstT'(iv);
		end
		return refKeystream(iv, b % `BKT_BURSTS);
	endfunction

	// ------------------------------------------------------------
	// Stream comparison at the transfer edge
	// ------------------------------------------------------------
	always @(posedge Clock) begin : compareStream
		int      path;
		int      slot;
		int      b;
		dramCmdT expCmd;
		burstT   expBurst;
		if (arstN) begin
			if (CmdValid && CmdReady) begin
				path        = cmdIdx / CmdsPerPath;
				slot        = cmdIdx % CmdsPerPath;
				b           = slot % `PATH_BURSTS;
				expCmd.op   = (slot < `PATH_BURSTS) ? OpRead : OpWrite;
				expCmd.addr = refAddr(refLeaf(path), b / `BKT_BURSTS, b % `BKT_BURSTS);
				if (Cmd !== expCmd) begin
					$display("ERROR %s command %0d: expected %h actual %h", curTest, cmdIdx,
						expCmd, Cmd);
					errors++;
				end
				cmdIdx++;
			end
			if (WrValid && WrReady) begin
				expBurst = refWriteBurst(wrIdx / `PATH_BURSTS, wrIdx % `PATH_BURSTS);
				if (WrData !== expBurst) begin
					$display("ERROR %s write burst %0d: expected %h actual %h", curTest, wrIdx,
						expBurst, WrData);
					errors++;
				end
				wrIdx++;
			end
		end
	end

	// ------------------------------------------------------------
	// Test helpers
	// ------------------------------------------------------------
	task automatic startTest(input string name);
		curTest           = name;
		testErrorsAtStart = errors;
	endtask

	task automatic reportTest();
		testsRun++;
		if (errors == testErrorsAtStart) begin
			$display("PASS %s", curTest);
		end else begin
			testsFailed++;
			$display("FAIL %s with %0d errors", curTest, errors - testErrorsAtStart);
		end
	endtask

	// Two cycles of reset, stream counters restart with it
	task automatic resetDut();
		@(negedge Clock);
		arstN  = 1'b0;
		cmdIdx = 0;
		wrIdx  = 0;
		repeat (2) @(negedge Clock);
		arstN = 1'b1;
	endtask

	// Runs until all write bursts of the paths have landed
	task automatic runPaths(input int paths);
		int          cycles;
		logic [15:0] lastCount;
		logic        flagged;
		cycles    = 0;
		lastCount = PathCount;
		flagged   = 1'b0;
		while (wrIdx < paths * `PATH_BURSTS && cycles < paths * CyclesPerPath) begin
			@(negedge Clock);
			cycles++;
			if (PathCount != lastCount) begin
				if (PathCount != lastCount + 16'd1) begin
					$display("ERROR %s PathCount step: expected %0d actual %0d", curTest,
						lastCount + 16'd1, PathCount);
					errors++;
				end
				lastCount = PathCount;
			end
			if ((Error || DataMismatch) && !flagged) begin
				$display("ERROR %s Error flag: expected 0 actual 1", curTest);
				errors++;
				flagged = 1'b1;
			end
		end
		if (wrIdx < paths * `PATH_BURSTS) begin
			$display("%s timed out with %0d of %0d write bursts done", curTest, wrIdx,
				paths * `PATH_BURSTS);
			errors++;
		end
		if (PathCount !== 16'(paths)) begin
			$display("ERROR %s PathCount: expected %0d actual %0d", curTest, paths, PathCount);
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin : runTests
		int   a;
		int   cycles;
		logic dropped;
		void'($urandom(32'hd325));
		arstN       = 1'b0;
		StallEn     = 1'b0;
		FlipArm     = 1'b0;
		errors      = 0;
		testsRun    = 0;
		testsFailed = 0;
		cmdIdx      = 0;
		wrIdx       = 0;
		curTest     = "init";
		// Buckets under IV zero, spare words get an address pattern
		for (a = 0; a < MemWords; a++) begin
			if (a >= NumBuckets * `BKT_BURSTS) begin
				i_dram.loadBurst(a, {32'(a) ^ 32'hA5C3_0F00, ~32'(a)});
			end else if (a % `BKT_BURSTS == 0) begin
				i_dram.loadBurst(a, '0);
			end else begin
				i_dram.loadBurst(a, refKeystream('0, a % `BKT_BURSTS));
			end
		end

		startTest("resetState");
		resetDut();
		if (CmdValid !== 1'b0) begin
			$display("ERROR %s CmdValid: expected 0 actual %b", curTest, CmdValid);
			errors++;
		end
		if (WrValid !== 1'b0) begin
			$display("ERROR %s WrValid: expected 0 actual %b", curTest, WrValid);
			errors++;
		end
		if (Error !== 1'b0) begin
			$display("ERROR %s Error: expected 0 actual %b", curTest, Error);
			errors++;
		end
		if (DataMismatch !== 1'b0) begin
			$display("ERROR %s DataMismatch: expected 0 actual %b", curTest, DataMismatch);
			errors++;
		end
		if (PathCount !== 16'd0) begin
			$display("ERROR %s PathCount: expected 0 actual %0d", curTest, PathCount);
			errors++;
		end
		reportTest();

		// Commands and write bursts against the reference
		startTest("pathStream");
		resetDut();
		runPaths(PathsPerTest);
		reportTest();

		// Same stream with ready stalls on both ports
		startTest("stalledStream");
		StallEn = 1'b1;
		resetDut();
		runPaths(PathsPerTest);
		StallEn = 1'b0;
		reportTest();

		// One flipped data bit must stop the producer after this path
		startTest("errorInject");
		FlipArm = 1'b1;
		resetDut();
		cycles = 0;
		while (!DataMismatch && cycles < CyclesPerPath) begin
			@(negedge Clock);
			cycles++;
		end
		if (!DataMismatch) begin
			$display("%s: DataMismatch did not rise after the flipped read", curTest);
			errors++;
		end
		cycles = 0;
		while (wrIdx < `PATH_BURSTS && cycles < CyclesPerPath) begin
			@(negedge Clock);
			cycles++;
		end
		if (wrIdx < `PATH_BURSTS) begin
			$display("%s: the current path did not finish its writes", curTest);
			errors++;
		end
		dropped = 1'b0;
		repeat (CyclesPerPath) begin
			@(negedge Clock);
			if ((Error !== 1'b1 || DataMismatch !== 1'b1) && !dropped) begin
				$display("%s: Error or DataMismatch fell after being set", curTest);
				errors++;
				dropped = 1'b1;
			end
		end
		if (cmdIdx != CmdsPerPath) begin
			$display("ERROR %s command count: expected %0d actual %0d", curTest, CmdsPerPath,
				cmdIdx);
			errors++;
		end
		if (CmdValid !== 1'b0) begin
			$display("ERROR %s CmdValid: expected 0 actual %b", curTest, CmdValid);
			errors++;
		end
		if (PathCount !== 16'd1) begin
			$display("ERROR %s PathCount: expected 1 actual %0d", curTest, PathCount);
			errors++;
		end
		FlipArm = 1'b0;
		reportTest();

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", testsRun,
			testsRun - testsFailed, testsFailed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Bound on the whole run, from paths, cycles per path and tests
	initial begin : watchdog
		#(WatchdogNs);
		$display("Watchdog expired: the run did not finish within %0d ns", WatchdogNs);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
